//--- msg_tx_top.f
+incdir+src
src/msg_tx_reg_pkg.sv
src/msg_tx_data_pkg.sv
src/msg_tx_apb_regs.sv
src/msg_tx_buffer.sv
src/tx_ext_fsm.sv
src/tx_byte_counter.sv
src/msg_tx_top.sv
test/msg_tx_tb.sv

//--- src/msg_tx_apb_regs.sv
`include "msg_tx_config.svh"
`default_nettype none

module msg_tx_apb_regs (
  input  wire                              clk,
  input  wire                              nrst,
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              pwrite,
  input  wire [`APB_ADDR_W-1:0]            paddr,
  input  wire [`APB_DATA_W-1:0]            pwdata,
  input  wire                              busy,
  input  wire                              done,
  output logic [`APB_DATA_W-1:0]           prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic                             start,
  output msg_tx_data_pkg::msg_index_t      length,
  output logic                             buf_we,
  output msg_tx_data_pkg::msg_index_t      buf_waddr,
  output msg_tx_data_pkg::msg_byte_t       buf_wdata
);

  localparam logic [`APB_ADDR_W-1:0] buf_end = msg_tx_reg_pkg::BUF_BASE + 4 * `MSG_DEPTH;

  logic access;
  logic is_ctrl, is_len, is_status, is_buf;
  logic mapped, blocked, wr_ok;
  logic done_q;
  msg_tx_data_pkg::msg_index_t len_clamped;

  assign access = psel && penable;  // no wait states so this is the completing cycle

  assign is_ctrl   = paddr == msg_tx_reg_pkg::CTRL;
  assign is_len    = paddr == msg_tx_reg_pkg::LEN;
  assign is_status = paddr == msg_tx_reg_pkg::STATUS;
  assign is_buf    = paddr >= msg_tx_reg_pkg::BUF_BASE && paddr < buf_end &&
                     paddr[1:0] == 2'b00;
  assign mapped    = is_ctrl || is_len || is_status || is_buf;

  // software may only clear done while a message is going out
  assign blocked = pwrite && busy && (is_ctrl || is_len || is_buf);
  assign wr_ok   = access && pwrite && mapped && !blocked;

  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || blocked);

  assign buf_we    = wr_ok && is_buf;
  assign buf_waddr = paddr[2 +: `MSG_IDX_W];
  assign buf_wdata = pwdata[7:0];

  assign len_clamped = (pwdata > `MSG_DEPTH) ? msg_tx_data_pkg::msg_index_t'(`MSG_DEPTH)
                                             : pwdata[`MSG_IDX_W-1:0];

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      start  <= 1'b0;
      length <= '0;
      done_q <= 1'b0;
    end else begin
      start <= wr_ok && is_ctrl && pwdata[msg_tx_reg_pkg::CTRL_START_BIT];
      if (wr_ok && is_len)
        length <= len_clamped;
      if (done)
        done_q <= 1'b1;  // a new completion wins over a clear in the same cycle
      else if (wr_ok && is_status && pwdata[msg_tx_reg_pkg::STATUS_DONE_BIT])
        done_q <= 1'b0;
    end
  end

  // the buffer window and CTRL read back as zero
  always_comb begin
    prdata = '0;
    if (is_len) begin
      prdata[`MSG_IDX_W-1:0] = length;
    end else if (is_status) begin
      prdata[msg_tx_reg_pkg::STATUS_BUSY_BIT] = busy;
      prdata[msg_tx_reg_pkg::STATUS_DONE_BIT] = done_q;
    end
  end

  // the FSM must have returned to idle before a new start is accepted
  a_start_idle : assert property (@(posedge clk) disable iff (!nrst)
    $rose(start) |-> !busy);

endmodule

`default_nettype wire

//--- src/msg_tx_buffer.sv
`include "msg_tx_config.svh"
`default_nettype none

module msg_tx_buffer (
  input  wire                               clk,
  input  wire                               nrst,
  input  wire                               we,
  input  wire msg_tx_data_pkg::msg_index_t  waddr,
  input  wire msg_tx_data_pkg::msg_byte_t   wdata,
  input  wire msg_tx_data_pkg::msg_index_t  raddr,
  output msg_tx_data_pkg::msg_byte_t        rdata
);

  localparam int slot_w = $clog2(`MSG_DEPTH);

  msg_tx_data_pkg::msg_byte_t mem [`MSG_DEPTH];

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < `MSG_DEPTH; i++)
        mem[i] <= '0;
    end else if (we) begin
      mem[waddr[slot_w-1:0]] <= wdata;
    end
  end

  // raddr reaches MSG_DEPTH once a full message has gone out
  assign rdata = (raddr < `MSG_DEPTH) ? mem[raddr[slot_w-1:0]] : '0;

  // the register block decodes the window, so no write may land past the end
  a_waddr_range : assert property (@(posedge clk) disable iff (!nrst)
    we |-> waddr < `MSG_DEPTH);

endmodule

`default_nettype wire

//--- src/msg_tx_config.svh
`ifndef MSG_TX_CONFIG_SVH
`define MSG_TX_CONFIG_SVH

// byte slots in the message buffer, also the largest length
`define MSG_DEPTH 16

// wide enough to hold a length of MSG_DEPTH
`define MSG_IDX_W 5

`define APB_ADDR_W 12
`define APB_DATA_W 32

`endif

//--- src/msg_tx_data_pkg.sv
`include "msg_tx_config.svh"
`default_nettype none

package msg_tx_data_pkg;

  typedef logic [7:0] msg_byte_t;

  typedef logic [`MSG_IDX_W-1:0] msg_index_t;  // index into the buffer or a length

  typedef enum logic [1:0] {IDLE = 2'd0, TRANSFER = 2'd1, STOP = 2'd2} tx_state_t;

endpackage

`default_nettype wire

//--- src/msg_tx_reg_pkg.sv
`include "msg_tx_config.svh"
`default_nettype none

package msg_tx_reg_pkg;

  // byte slot k of the buffer sits at BUF_BASE + 4*k
  typedef enum logic [`APB_ADDR_W-1:0] {
    CTRL     = 'h000,  // bit 0 start, write only
    LEN      = 'h004,
    STATUS   = 'h008,
    BUF_BASE = 'h100
  } reg_addr_e;

  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;  // sticky, write 1 to clear

endpackage

`default_nettype wire

//--- src/msg_tx_top.sv
`include "msg_tx_config.svh"
`default_nettype none

module msg_tx_top (
  input  wire                          clk,
  input  wire                          nrst,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [`APB_ADDR_W-1:0]        paddr,
  input  wire [`APB_DATA_W-1:0]        pwdata,
  input  wire                          tx_ready,
  output logic [`APB_DATA_W-1:0]       prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         tx_valid,
  output msg_tx_data_pkg::msg_byte_t   tx_data
);

  logic start;
  logic buf_we;
  logic stop;
  logic count_enable;
  logic busy;
  logic done;
  msg_tx_data_pkg::msg_index_t length;
  msg_tx_data_pkg::msg_index_t buf_waddr;
  msg_tx_data_pkg::msg_index_t rd_index;
  msg_tx_data_pkg::msg_byte_t  buf_wdata;
  msg_tx_data_pkg::msg_byte_t  rd_data;

  msg_tx_apb_regs msg_tx_apb_regs_i (
    .clk(clk), .nrst(nrst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .busy(busy), .done(done),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .start(start), .length(length),
    .buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata)
  );

  msg_tx_buffer msg_tx_buffer_i (
    .clk(clk), .nrst(nrst),
    .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
    .raddr(rd_index), .rdata(rd_data)
  );

  tx_ext_fsm tx_ext_fsm_i (
    .clk(clk), .nrst(nrst),
    .transmit_ready(tx_ready), .msg_tx_ctrl(start), .stop(stop),
    .tx_ctrl(tx_valid), .count_enable(count_enable), .busy(busy), .done(done)
  );

  tx_byte_counter tx_byte_counter_i (
    .clk(clk), .nrst(nrst),
    .start(start), .count_enable(count_enable), .length(length), .rd_data(rd_data),
    .rd_index(rd_index), .stop(stop), .tx_data(tx_data)
  );

endmodule

`default_nettype wire

//--- src/tx_byte_counter.sv
`default_nettype none

module tx_byte_counter (
  input  wire                               clk,
  input  wire                               nrst,
  input  wire                               start,
  input  wire                               count_enable,
  input  wire msg_tx_data_pkg::msg_index_t  length,
  input  wire msg_tx_data_pkg::msg_byte_t   rd_data,
  output msg_tx_data_pkg::msg_index_t       rd_index,
  output logic                              stop,
  output msg_tx_data_pkg::msg_byte_t        tx_data
);

  // rd_index counts issued bytes and also addresses the next one
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst)
      rd_index <= '0;
    else if (start)
      rd_index <= '0;
    else if (count_enable)
      rd_index <= rd_index + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (count_enable)
      tx_data <= rd_data;  // latched together with the index step
  end

  // high right away for a zero length message
  assign stop = rd_index == length;

  // the FSM only issues while bytes remain, so the count never runs past length
  a_index_bound : assert property (@(posedge clk) disable iff (!nrst)
    count_enable |-> rd_index < length);

endmodule

`default_nettype wire

//--- src/tx_ext_fsm.sv
`default_nettype none

module tx_ext_fsm (
  input  wire   clk,
  input  wire   nrst,
  input  wire   transmit_ready,
  input  wire   msg_tx_ctrl,
  input  wire   stop,
  output logic  tx_ctrl,
  output logic  count_enable,
  output logic  busy,
  output logic  done
);

  msg_tx_data_pkg::tx_state_t state, next_state;
  logic next_tx_ctrl;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state   <= msg_tx_data_pkg::IDLE;
      tx_ctrl <= 1'b0;
    end else begin
      state   <= next_state;
      tx_ctrl <= next_tx_ctrl;  // the byte goes out one cycle after the credit
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      msg_tx_data_pkg::IDLE: begin
        if (msg_tx_ctrl)
          next_state = msg_tx_data_pkg::TRANSFER;
      end
      msg_tx_data_pkg::TRANSFER: begin
        if (stop)
          next_state = msg_tx_data_pkg::STOP;
      end
      msg_tx_data_pkg::STOP: begin
        next_state = msg_tx_data_pkg::IDLE;  // one cycle only, long enough to flag done
      end
      default: begin
        next_state = msg_tx_data_pkg::IDLE;
      end
    endcase
  end

  // stop is checked first so a credit in the last cycle issues nothing
  always_comb begin
    next_tx_ctrl = 1'b0;
    count_enable = 1'b0;
    if (state == msg_tx_data_pkg::TRANSFER && !stop && transmit_ready) begin
      next_tx_ctrl = 1'b1;
      count_enable = 1'b1;
    end
  end

  assign busy = state != msg_tx_data_pkg::IDLE;
  assign done = state == msg_tx_data_pkg::STOP;

  // the register block refuses a start during a transfer so one only arrives in IDLE
  a_start_in_idle : assert property (@(posedge clk) disable iff (!nrst)
    msg_tx_ctrl |-> state == msg_tx_data_pkg::IDLE);

endmodule

`default_nettype wire

//--- test/msg_tx_tb.sv
`include "msg_tx_config.svh"
`default_nettype none

module msg_tx_tb;

  logic clk = 1'b0;
  logic nrst;
  logic psel, penable, pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`APB_DATA_W-1:0] pwdata;
  logic tx_ready;
  wire [`APB_DATA_W-1:0] prdata;
  wire pready, pslverr, tx_valid;
  wire msg_tx_data_pkg::msg_byte_t tx_data;

  logic chk_rd, exp_err;
  logic [`APB_DATA_W-1:0] exp_rdata, rd_value;
  msg_tx_data_pkg::msg_byte_t sb_mem [`MSG_DEPTH];
  msg_tx_data_pkg::msg_index_t slen;
  int icount, vcount;  // bytes issued by the model and bytes seen on tx_valid
  logic arm, active, stopping, exp_valid, model_busy;
  logic [31:0] rng = 32'hda8b65d5;
  int errors = 0;
  logic hung = 1'b0;

  always #10 clk = ~clk;

  msg_tx_top msg_tx_top_i (
    .clk(clk), .nrst(nrst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .tx_ready(tx_ready),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .tx_valid(tx_valid), .tx_data(tx_data)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // the sink hands out credits at random
  always @(posedge clk) begin
    rng <= lcg_next(rng);
    tx_ready <= rng[23];
  end

  assign model_busy = active || stopping;

  // reference model of the credit rule, fed by completed APB writes
  always @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      arm <= 1'b0;
      active <= 1'b0;
      stopping <= 1'b0;
      exp_valid <= 1'b0;
      icount <= 0;
      vcount <= 0;
      slen <= '0;
      for (int i = 0; i < `MSG_DEPTH; i++)
        sb_mem[i] <= '0;
    end else begin
      exp_valid <= active && tx_ready && icount < slen;
      if (tx_valid)
        vcount <= vcount + 1;
      arm <= 1'b0;
      stopping <= 1'b0;
      if (arm) begin
        active <= 1'b1;
        icount <= 0;
        vcount <= 0;
      end else if (active) begin
        if (icount == slen) begin
          active <= 1'b0;
          stopping <= 1'b1;
        end else if (tx_ready) begin
          icount <= icount + 1;
        end
      end
      if (psel && penable && pwrite && !model_busy) begin
        if (paddr == msg_tx_reg_pkg::CTRL && pwdata[0])
          arm <= 1'b1;
        if (paddr == msg_tx_reg_pkg::LEN)
          slen <= (pwdata > `MSG_DEPTH) ? `MSG_DEPTH : pwdata[`MSG_IDX_W-1:0];
        if (paddr >= msg_tx_reg_pkg::BUF_BASE && paddr[1:0] == 2'b00 &&
            paddr < msg_tx_reg_pkg::BUF_BASE + 4 * `MSG_DEPTH)
          sb_mem[(paddr - msg_tx_reg_pkg::BUF_BASE) >> 2] <= pwdata[7:0];
      end
    end
  end

  a_pslverr : assert property (@(posedge clk) disable iff (!nrst)
    psel && penable |-> pready && pslverr == exp_err)
    else begin
      errors = errors + 1;
      $display("** Error: pslverr expected %h actual %h at paddr %h",
               $sampled(exp_err), $sampled(pslverr), $sampled(paddr));
    end

  a_prdata : assert property (@(posedge clk) disable iff (!nrst)
    psel && penable && !pwrite && chk_rd |-> prdata == exp_rdata)
    else begin
      errors = errors + 1;
      $display("** Error: prdata expected %h actual %h at paddr %h",
               $sampled(exp_rdata), $sampled(prdata), $sampled(paddr));
    end

  a_valid : assert property (@(posedge clk) disable iff (!nrst) tx_valid == exp_valid)
    else begin
      errors = errors + 1;
      $display("** Error: tx_valid expected %h actual %h in state %s",
               $sampled(exp_valid), $sampled(tx_valid), msg_tx_top_i.tx_ext_fsm_i.state.name());
    end

  a_data : assert property (@(posedge clk) disable iff (!nrst)
    tx_valid |-> tx_data == sb_mem[vcount])
    else begin
      errors = errors + 1;
      $display("** Error: tx_data expected %h actual %h",
               $sampled(sb_mem[vcount]), $sampled(tx_data));
    end

  // the last byte has gone out by the time the FSM sits in STOP
  a_count : assert property (@(posedge clk) disable iff (!nrst) stopping |-> vcount == slen)
    else begin
      errors = errors + 1;
      $display("** Error: byte count expected %h actual %h", $sampled(slen), $sampled(vcount));
    end

  task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [`APB_DATA_W-1:0] data, input logic err,
                            input logic chk, input logic [`APB_DATA_W-1:0] rexp);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= data;
    exp_err <= err;
    chk_rd <= chk;
    exp_rdata <= rexp;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rd_value = prdata;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
                           input logic [`APB_DATA_W-1:0] data, input logic err);
    apb_access(1'b1, addr, data, err, 1'b0, '0);
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, input logic err,
                          input logic chk, input logic [`APB_DATA_W-1:0] rexp);
    apb_access(1'b0, addr, '0, err, chk, rexp);
  endtask

  task automatic fill_buffer(input int base);
    for (int k = 0; k < `MSG_DEPTH; k++)
      apb_write(msg_tx_reg_pkg::BUF_BASE + 4 * k, (k * 29 + base) & 255, 1'b0);
  endtask

  // polls STATUS until busy drops
  task automatic wait_idle();
    int polls = 0;
    logic idle = 1'b0;
    while (!idle && polls < 60) begin
      apb_read(msg_tx_reg_pkg::STATUS, 1'b0, 1'b0, '0);
      idle = !rd_value[msg_tx_reg_pkg::STATUS_BUSY_BIT];
      polls++;
    end
    if (!idle) begin
      $display("timeout: the transfer was still busy after %0d status polls", polls);
      hung = 1'b1;
    end
  endtask

  task automatic send_message();
    apb_write(msg_tx_reg_pkg::CTRL, 32'h1, 1'b0);
    wait_idle();
    if (hung)
      return;
    apb_read(msg_tx_reg_pkg::STATUS, 1'b0, 1'b1, 1 << msg_tx_reg_pkg::STATUS_DONE_BIT);
    apb_write(msg_tx_reg_pkg::STATUS, 1 << msg_tx_reg_pkg::STATUS_DONE_BIT, 1'b0);
    apb_read(msg_tx_reg_pkg::STATUS, 1'b0, 1'b1, 32'h0);
  endtask

  task automatic run_tests();
    apb_write(msg_tx_reg_pkg::LEN, 32'd5, 1'b0);
    apb_read(msg_tx_reg_pkg::LEN, 1'b0, 1'b1, 32'd5);
    apb_write(msg_tx_reg_pkg::LEN, 32'd20, 1'b0);  // clamps to the buffer depth
    apb_read(msg_tx_reg_pkg::LEN, 1'b0, 1'b1, 32'd16);
    apb_read(msg_tx_reg_pkg::STATUS, 1'b0, 1'b1, 32'h0);
    apb_read(12'h00c, 1'b1, 1'b0, '0);
    apb_write(12'h200, 32'h1, 1'b1);
    fill_buffer(8'h3b);
    apb_write(msg_tx_reg_pkg::LEN, 32'd1, 1'b0);
    send_message();
    if (hung)
      return;
    apb_write(msg_tx_reg_pkg::LEN, 32'd5, 1'b0);
    send_message();
    if (hung)
      return;
    apb_write(msg_tx_reg_pkg::LEN, 32'd16, 1'b0);
    send_message();
    if (hung)
      return;
    apb_write(msg_tx_reg_pkg::LEN, 32'd0, 1'b0);
    send_message();
    if (hung)
      return;
    // writes during a long transfer are refused and leave everything as it was
    apb_write(msg_tx_reg_pkg::LEN, 32'd16, 1'b0);
    apb_write(msg_tx_reg_pkg::CTRL, 32'h1, 1'b0);
    apb_write(msg_tx_reg_pkg::LEN, 32'd3, 1'b1);
    apb_write(msg_tx_reg_pkg::BUF_BASE + 8, 32'hff, 1'b1);
    apb_write(msg_tx_reg_pkg::CTRL, 32'h1, 1'b1);
    wait_idle();
    if (hung)
      return;
    apb_read(msg_tx_reg_pkg::LEN, 1'b0, 1'b1, 32'd16);
    apb_write(msg_tx_reg_pkg::STATUS, 1 << msg_tx_reg_pkg::STATUS_DONE_BIT, 1'b0);
    send_message();
  endtask

  initial begin
    nrst = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    tx_ready = 1'b0;
    chk_rd = 1'b0;
    exp_err = 1'b0;
    exp_rdata = '0;
    rd_value = '0;
    repeat (3) @(posedge clk);
    nrst <= 1'b1;
    run_tests();
    repeat (4) @(posedge clk);
    $display("run finished with %0d errors, timeout %0d", errors, hung);
    if (errors == 0 && !hung)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
